// File: Makefile
VERILATOR ?= verilator
TOP       ?= riscv64_subsys_tb
FILELIST  ?= riscv64_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard src/*.sv src/*.svh verif/*.sv verif/*.svh)

.PHONY: compile run clean

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: riscv64_subsys.f
+incdir+src
+incdir+verif
src/riscv64_pkg.sv
src/riscv64_csr.sv
src/riscv64_exec.sv
src/riscv64_wb_master.sv
src/riscv64_subsys.sv
verif/riscv64_subsys_tb.sv

// File: src/riscv64_consts.svh
`ifndef RISCV64_CONSTS_SVH
`define RISCV64_CONSTS_SVH

// fetch address out of reset
`define RV_RESET_PC       64'h0000_0000_0000_0000
`define RV_TRAP_VEC       64'h0000_0000_0000_0100  // single vector, no mtvec

// major opcodes
`define RV_OP_LUI         7'b0110111
`define RV_OP_IMM         7'b0010011
`define RV_OP_LOAD        7'b0000011
`define RV_OP_STORE       7'b0100011

// funct3 codes
`define RV_F3_ADDI        3'b000
`define RV_F3_D           3'b011   // doubleword for LD and SD

// mstatus bits that exist here
`define RV_MSTATUS_MIE    3
`define RV_MSTATUS_MPIE   7

// whole words
`define RV_MRET           32'h3020_0073
`define RV_NOP            32'h0000_0013  // addi x0, x0, 0

`endif

// File: src/riscv64_csr.sv
`default_nettype none
`include "riscv64_consts.svh"

module riscv64_csr (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         irq,        // level-sensitive machine external
    input  wire riscv64_pkg::trap_ctl_t trap_ctl,
    output riscv64_pkg::csr_ctl_t       csr_ctl,
    output logic                        irq_ack
);

    // only MIE and MPIE ever move
    logic [63:0] mstatus;
    logic [63:0] mepc;
    logic        take;

    // interrupt taken when enabled and execute can drop its word
    assign take = irq && mstatus[`RV_MSTATUS_MIE] && trap_ctl.interruptible;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus <= 64'd1 << `RV_MSTATUS_MIE;   // interrupts on out of reset
            mepc    <= 64'd0;
            irq_ack <= 1'b0;
        end else begin
            irq_ack <= take;   // reply one cycle later
            if (take) begin
                // trap entry
                mepc                      <= trap_ctl.epc;
                mstatus[`RV_MSTATUS_MPIE] <= mstatus[`RV_MSTATUS_MIE];
                mstatus[`RV_MSTATUS_MIE]  <= 1'b0;
            end else if (trap_ctl.mret) begin
                // mret restores the previous enable
                mstatus[`RV_MSTATUS_MIE]  <= mstatus[`RV_MSTATUS_MPIE];
                mstatus[`RV_MSTATUS_MPIE] <= 1'b1;
            end
        end
    end

    assign csr_ctl = '{take: take, mepc: mepc};

    // entry clears MIE and parks the enable that allowed it in MPIE
    a_entry_saves_mie: assert property (
        @(posedge clk) disable iff (!reset)
        irq_ack |-> !mstatus[`RV_MSTATUS_MIE] && mstatus[`RV_MSTATUS_MPIE]
    );

    // MIE drops on entry so a held irq cannot ack twice in a row
    a_ack_single: assert property (
        @(posedge clk) disable iff (!reset)
        irq_ack |=> !irq_ack
    );

endmodule

`default_nettype wire

// File: src/riscv64_exec.sv
`default_nettype none
`include "riscv64_consts.svh"

module riscv64_exec (
    input  wire                        clk,
    input  wire                        reset,
    input  wire [31:0]                 instruction,  // word at pc, same cycle
    input  wire riscv64_pkg::csr_ctl_t csr_ctl,
    input  wire riscv64_pkg::mem_rsp_t mem_rsp,
    output logic [63:0]                pc,
    output logic                       heartbeat,
    output riscv64_pkg::trap_ctl_t     trap_ctl,
    output riscv64_pkg::mem_req_t      mem_req
);

    riscv64_pkg::rv_insn_u ir;   // fetch register
    logic        bubble;         // ir holds no real instruction
    logic [63:0] ir_pc;          // where ir came from
    logic        mem_busy;       // bus cycle already launched for ir
    logic [63:0] regs [32];

    logic        real_insn;
    logic        is_lui;
    logic        is_addi;
    logic        is_ld;
    logic        is_sd;
    logic        is_mret;
    logic        is_mem;
    logic        take;
    logic        stall;
    logic        retire_mret;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [63:0] rs1_val;
    logic [63:0] rs2_val;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_u;
    logic        rd_we;
    logic [63:0] rd_val;
    logic [63:0] pc_next;

    // decode
    assign real_insn = !bubble;
    assign is_lui  = ir.u_view.opcode == `RV_OP_LUI;
    assign is_addi = (ir.i_view.opcode == `RV_OP_IMM) && (ir.i_view.funct3 == `RV_F3_ADDI);
    assign is_ld   = (ir.i_view.opcode == `RV_OP_LOAD) && (ir.i_view.funct3 == `RV_F3_D);
    assign is_sd   = (ir.s_view.opcode == `RV_OP_STORE) && (ir.s_view.funct3 == `RV_F3_D);
    assign is_mret = ir == `RV_MRET;
    assign is_mem  = real_insn && (is_ld || is_sd);

    assign rs1 = ir.i_view.rs1;
    assign rs2 = ir.s_view.rs2;
    assign rd  = ir.i_view.rd;   // same bits as u_view.rd

    // x0 reads as zero
    assign rs1_val = (rs1 == 5'd0) ? 64'd0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? 64'd0 : regs[rs2];

    // sign-extended immediates
    assign imm_i = {{52{ir.i_view.imm12[11]}}, ir.i_view.imm12};
    assign imm_s = {{52{ir.s_view.imm_hi[6]}}, ir.s_view.imm_hi, ir.s_view.imm_lo};
    assign imm_u = {{32{ir.u_view.imm20[19]}}, ir.u_view.imm20, 12'd0};

    // interrupt wins over everything in ir, including a fresh LD or SD
    assign take        = csr_ctl.take;
    assign retire_mret = real_insn && is_mret && !take;
    assign stall       = is_mem && !mem_rsp.done && !take;   // freeze until done

    // request held from the first ir cycle through done
    assign mem_req = '{
        valid: is_mem && !take,
        write: is_sd,
        addr:  rs1_val + (is_sd ? imm_s : imm_i),
        wdata: rs2_val
    };

    // only a word with no bus cycle out may be dropped
    assign trap_ctl = '{
        interruptible: real_insn && !mem_busy,
        epc:           ir_pc,
        mret:          retire_mret
    };

    // register writeback
    always_comb begin
        rd_we  = 1'b0;
        rd_val = imm_u;
        if (real_insn && !take) begin
            if (is_lui) begin
                rd_we = 1'b1;
            end else if (is_addi) begin
                rd_we  = 1'b1;
                rd_val = rs1_val + imm_i;
            end else if (is_ld && mem_rsp.done) begin
                rd_we  = 1'b1;              // load lands in the done cycle
                rd_val = mem_rsp.rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_we && (rd != 5'd0)) begin   // x0 writes dropped
            regs[rd] <= rd_val;
        end
    end

    // next pc, trap first then mret then stall
    always_comb begin
        if (take) begin
            pc_next = `RV_TRAP_VEC;
        end else if (retire_mret) begin
            pc_next = csr_ctl.mepc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 64'd4;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc        <= `RV_RESET_PC;
            bubble    <= 1'b1;   // nothing fetched yet
            mem_busy  <= 1'b0;
            heartbeat <= 1'b0;
        end else begin
            pc        <= pc_next;
            heartbeat <= ~heartbeat;
            mem_busy  <= mem_req.valid && !mem_rsp.done;
            if (!stall) begin
                bubble <= take || retire_mret;   // word fetched beside a redirect
            end
        end
    end

    // fetch register, validity lives in bubble
    always_ff @(posedge clk) begin
        if (!stall) begin
            ir    <= instruction;
            ir_pc <= pc;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!reset)
        pc[1:0] == 2'b00
    );

    // master sees one steady request across all wait states
    a_req_stable: assert property (
        @(posedge clk) disable iff (!reset)
        mem_req.valid && !mem_rsp.done |=> $stable(mem_req)
    );

endmodule

`default_nettype wire

// File: src/riscv64_pkg.sv
`default_nettype none

package riscv64_pkg;

    // one instruction word, three ways of reading it
    typedef union packed {
        struct packed {
            logic [19:0] imm20;   // upper immediate
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_view;                 // lui
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;                 // addi, ld
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s_view;                 // sd
    } rv_insn_u;

    // execute to bus master
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [63:0] addr;
        logic [63:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        done;    // one cycle, after ack
        logic [63:0] rdata;
    } mem_rsp_t;

    // wishbone classic, master side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [63:0] adr;
        logic [63:0] dat_w;
    } wb_m2s_t;

    typedef struct packed {
        logic        ack;
        logic [63:0] dat_r;
    } wb_s2m_t;

    // execute to csr block
    typedef struct packed {
        logic        interruptible;
        logic [63:0] epc;
        logic        mret;
    } trap_ctl_t;

    // csr block back to execute
    typedef struct packed {
        logic        take;
        logic [63:0] mepc;
    } csr_ctl_t;

endpackage

`default_nettype wire

// File: src/riscv64_subsys.sv
`default_nettype none

module riscv64_subsys (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [31:0]                instruction,   // program memory, same cycle
    output wire [63:0]                pc,
    input  wire                       irq,
    output wire                       irq_ack,
    output wire                       heartbeat,
    output wire riscv64_pkg::wb_m2s_t wb_o,          // data bus out
    input  wire riscv64_pkg::wb_s2m_t wb_i
);

    wire riscv64_pkg::trap_ctl_t trap_ctl;   // exec to csr
    wire riscv64_pkg::csr_ctl_t  csr_ctl;    // csr to exec
    wire riscv64_pkg::mem_req_t  mem_req;
    wire riscv64_pkg::mem_rsp_t  mem_rsp;

    // fetch, decode, execute
    riscv64_exec i_exec (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .csr_ctl     (csr_ctl),
        .mem_rsp     (mem_rsp),
        .pc          (pc),
        .heartbeat   (heartbeat),
        .trap_ctl    (trap_ctl),
        .mem_req     (mem_req)
    );

    // machine csrs and interrupt decision
    riscv64_csr i_csr (
        .clk      (clk),
        .reset    (reset),
        .irq      (irq),
        .trap_ctl (trap_ctl),
        .csr_ctl  (csr_ctl),
        .irq_ack  (irq_ack)
    );

    // one request in, one classic cycle out
    riscv64_wb_master i_wb_master (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .wb_i    (wb_i),
        .mem_rsp (mem_rsp),
        .wb_o    (wb_o)
    );

endmodule

`default_nettype wire

// File: src/riscv64_wb_master.sv
`default_nettype none

module riscv64_wb_master (
    input  wire                        clk,
    input  wire                        reset,
    input  wire riscv64_pkg::mem_req_t mem_req,
    input  wire riscv64_pkg::wb_s2m_t  wb_i,
    output riscv64_pkg::mem_rsp_t      mem_rsp,
    output riscv64_pkg::wb_m2s_t       wb_o
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t      state;
    logic        cyc_q;     // cyc and stb move together
    logic        we_q;
    logic        done_q;    // completion pulse to execute
    logic [63:0] adr_q;
    logic [63:0] dat_w_q;
    logic [63:0] rdata_q;
    logic        launch;
    logic        finish;

    // req stays up in the done cycle so skip it there
    assign launch = (state == ST_IDLE) && mem_req.valid && !done_q;
    assign finish = (state == ST_BUSY) && wb_i.ack;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state  <= ST_IDLE;
            cyc_q  <= 1'b0;
            we_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= finish;
            if (launch) begin
                state <= ST_BUSY;
                cyc_q <= 1'b1;
                we_q  <= mem_req.write;
            end else if (finish) begin
                state <= ST_IDLE;   // cyc and stb drop on the edge after ack
                cyc_q <= 1'b0;
                we_q  <= 1'b0;
            end
        end
    end

    // address and data held for the whole cycle
    always_ff @(posedge clk) begin
        if (launch) begin
            adr_q   <= mem_req.addr;
            dat_w_q <= mem_req.wdata;
        end
        if (finish) begin
            rdata_q <= wb_i.dat_r;   // sampled in the ack cycle
        end
    end

    assign wb_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat_w: dat_w_q};
    assign mem_rsp = '{done: done_q, rdata: rdata_q};

    // a strobe in wait states stays inside cyc with steady contents
    a_hold_until_ack: assert property (
        @(posedge clk) disable iff (!reset)
        wb_o.stb && !wb_i.ack |=>
            wb_o.cyc && wb_o.stb && $stable({wb_o.we, wb_o.adr, wb_o.dat_w})
    );

endmodule

`default_nettype wire

// File: verif/riscv64_tb_checks.svh
`ifndef RISCV64_TB_CHECKS_SVH
`define RISCV64_TB_CHECKS_SVH

int mismatch_count = 0;
int timeout_count  = 0;

task automatic check_u64(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_wb(input string name, input riscv64_pkg::wb_m2s_t got,
                        input riscv64_pkg::wb_m2s_t exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

// encoders for the base ISA formats
function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, `RV_OP_LUI};
endfunction

function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, `RV_F3_ADDI, rd, `RV_OP_IMM};
endfunction

function automatic logic [31:0] enc_ld(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, `RV_F3_D, rd, `RV_OP_LOAD};
endfunction

function automatic logic [31:0] enc_sd(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, `RV_F3_D, imm[4:0], `RV_OP_STORE};   // split immediate
endfunction

function automatic logic [63:0] sext12(input logic [11:0] v);
    return 64'($signed(v));
endfunction

// lui on rv64 sign-extends the 32-bit result
function automatic logic [63:0] upper_imm(input logic [19:0] v);
    return 64'($signed({v, 12'h000}));
endfunction

// what the slave should see at ack for one store
function automatic riscv64_pkg::wb_m2s_t bus_write(input logic [63:0] addr,
                                                   input logic [63:0] data);
    return '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat_w: data};
endfunction

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic draw_lfsr_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);   // one step per bit
        v    = {v[62:0], lfsr[0]};
    end
endtask

task automatic next_cycle();
    @(tick);   // falling edge after the models have updated
endtask

task automatic report_timeout(input string what);
    timeout_count++;
    $display("timeout at %0t: %s never came", $time, what);
endtask

task automatic wait_pc(input logic [63:0] target, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (pc !== target && cycles < limit) begin
        next_cycle();
        cycles++;
    end
    if (pc !== target) begin
        report_timeout(what);
    end
endtask

task automatic wait_writes(input int n, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (wr_log.size() < n && cycles < limit) begin
        next_cycle();
        cycles++;
    end
    if (wr_log.size() < n) begin
        report_timeout(what);
    end
endtask

task automatic wait_acks(input int n, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (ack_count < n && cycles < limit) begin
        next_cycle();
        cycles++;
    end
    if (ack_count < n) begin
        report_timeout(what);
    end
endtask

`endif

// File: verif/riscv64_subsys_tb.sv
`default_nettype none
`include "riscv64_consts.svh"

module riscv64_subsys_tb;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      irq;
    logic [31:0]               instruction = `RV_NOP;
    riscv64_pkg::wb_s2m_t      wb_i = '0;
    wire  [63:0]               pc;
    wire                       irq_ack;
    wire                       heartbeat;
    wire riscv64_pkg::wb_m2s_t wb_o;

    logic [31:0]          prog_mem [256];          // word index is pc[9:2]
    logic [63:0]          data_mem [logic [63:0]]; // sparse and keyed by byte address
    riscv64_pkg::wb_m2s_t wr_log [$];              // bus state at each write ack
    logic [15:0]          lfsr = 16'd28919;
    logic [63:0]          draw;
    logic [1:0]           wait_left;               // wait states still owed
    logic                 in_cycle  = 1'b0;
    logic                 cyc_seen  = 1'b0;
    logic [63:0]          pc_at_cyc;
    int                   bus_cycles;
    int                   ack_count;
    event                 tick;

    `include "riscv64_tb_checks.svh"

    riscv64_subsys i_riscv64_subsys (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .irq         (irq),
        .irq_ack     (irq_ack),
        .heartbeat   (heartbeat),
        .wb_o        (wb_o),
        .wb_i        (wb_i)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // unwritten words get a pattern of the whole address
    function automatic logic [63:0] read_word(input logic [63:0] adr);
        if (data_mem.exists(adr)) begin
            return data_mem[adr];
        end
        return {~adr[31:0], adr[63:32]} ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    // program memory, wishbone slave and bus monitor run on the falling edge
    always @(negedge clk) begin
        if (pc[63:10] == 54'd0) begin
            instruction = prog_mem[pc[9:2]];
        end else begin
            instruction = `RV_NOP;   // past the program
        end
        if (!reset) begin
            wb_i       = '0;   // model restarts with the DUT
            in_cycle   = 1'b0;
            cyc_seen   = 1'b0;
            bus_cycles = 0;
            ack_count  = 0;
            wr_log.delete();
        end else begin
            if (wb_i.ack) begin
                wb_i.ack = 1'b0;   // cyc already dropped
                in_cycle = 1'b0;
            end else if (wb_o.cyc && wb_o.stb) begin
                if (!in_cycle) begin
                    in_cycle = 1'b1;
                    draw_lfsr_bits(2, draw);
                    wait_left = draw[1:0];   // 0 to 3 wait states
                end
                if (wait_left == 2'd0) begin
                    wb_i.ack = 1'b1;
                    bus_cycles++;
                    if (wb_o.we) begin
                        wr_log.push_back(wb_o);
                    end else begin
                        wb_i.dat_r = read_word(wb_o.adr);
                    end
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
            // fetch frozen for the whole bus cycle
            if (wb_o.cyc) begin
                if (cyc_seen) begin
                    check_u64("pc during bus cycle", pc, pc_at_cyc);
                end
                cyc_seen  = 1'b1;
                pc_at_cyc = pc;
            end else begin
                cyc_seen = 1'b0;
            end
            if (irq_ack) begin
                ack_count++;
            end
        end
        -> tick;
    end

    // reset goes low and program memory is refilled with NOPs
    task automatic hold_in_reset();
        next_cycle();
        reset = 1'b0;
        irq   = 1'b0;
        data_mem.delete();
        for (int i = 0; i < 256; i++) begin
            prog_mem[i] = `RV_NOP;
        end
    endtask

    task automatic release_after_reset();
        repeat (4) begin
            next_cycle();
            check_u64("pc in reset", pc, `RV_RESET_PC);
            check_bit("wb_o.cyc in reset", wb_o.cyc, 1'b0);
            check_bit("wb_o.stb in reset", wb_o.stb, 1'b0);
            check_bit("irq_ack in reset", irq_ack, 1'b0);
            check_bit("heartbeat in reset", heartbeat, 1'b0);
        end
        reset = 1'b1;
        check_u64("pc at reset release", pc, `RV_RESET_PC);
    endtask

    task automatic reset_and_heartbeat();
        logic prev;
        hold_in_reset();
        release_after_reset();
        prev = heartbeat;
        repeat (8) begin
            next_cycle();
            check_bit("heartbeat", heartbeat, ~prev);
            prev = heartbeat;
        end
    endtask

    task automatic stores_from_arith();
        logic [63:0] x1;
        logic [63:0] x2;
        hold_in_reset();
        prog_mem[0] = enc_lui(5'd1, 20'h80123);          // negative upper immediate
        prog_mem[1] = enc_addi(5'd1, 5'd1, 12'h456);
        prog_mem[2] = enc_addi(5'd2, 5'd0, 12'h200);
        prog_mem[3] = enc_sd(5'd1, 5'd2, 12'h010);
        prog_mem[4] = enc_addi(5'd0, 5'd0, 12'h005);    // dropped so x0 stays zero
        prog_mem[5] = enc_sd(5'd0, 5'd2, 12'hff8);      // offset -8
        x1 = upper_imm(20'h80123) + sext12(12'h456);
        x2 = sext12(12'h200);
        release_after_reset();
        wait_writes(2, 60, "both stores of the arithmetic program");
        if (wr_log.size() >= 2) begin
            check_wb("store of x1", wr_log[0], bus_write(x2 + sext12(12'h010), x1));
            check_wb("store of x0", wr_log[1], bus_write(x2 + sext12(12'hff8), 64'd0));
        end
        check_u64("bus cycles for two stores", 64'(bus_cycles), 64'd2);
    endtask

    task automatic loads_under_stall();
        logic [63:0] word_a;
        logic [63:0] word_b;
        hold_in_reset();
        draw_lfsr_bits(64, word_a);
        draw_lfsr_bits(64, word_b);
        data_mem[64'h308] = word_a;
        data_mem[64'h310] = word_b;
        prog_mem[0] = enc_addi(5'd4, 5'd0, 12'h300);    // base
        prog_mem[1] = enc_ld(5'd3, 5'd4, 12'h008);
        prog_mem[2] = enc_sd(5'd3, 5'd4, 12'h040);      // uses the load right away
        prog_mem[3] = enc_ld(5'd5, 5'd4, 12'h010);
        prog_mem[4] = enc_sd(5'd5, 5'd4, 12'h048);
        release_after_reset();
        wait_writes(2, 120, "copies of the loaded words");
        if (wr_log.size() >= 2) begin
            check_wb("copy of first load", wr_log[0], bus_write(64'h340, word_a));
            check_wb("copy of second load", wr_log[1], bus_write(64'h348, word_b));
        end
        check_u64("bus cycles for four accesses", 64'(bus_cycles), 64'd4);
    endtask

    task automatic irq_entry();
        hold_in_reset();
        prog_mem[70] = `RV_MRET;   // handler is six NOPs from the vector
        release_after_reset();
        wait_pc(64'd16, 20, "pc reaching the NOP run");
        irq = 1'b1;
        wait_acks(1, 10, "interrupt acknowledge");
        check_u64("pc at irq_ack", pc, `RV_TRAP_VEC);
        repeat (4) begin
            next_cycle();   // irq still high while MIE is clear
        end
        check_u64("acks with irq held in handler", 64'(ack_count), 64'd1);
        irq = 1'b0;
    endtask

    task automatic mret_return();
        logic [63:0] epc;
        hold_in_reset();
        prog_mem[0]  = enc_addi(5'd6, 5'd0, 12'h400);
        prog_mem[1]  = enc_addi(5'd7, 5'd0, 12'h5a5);
        prog_mem[5]  = enc_sd(5'd7, 5'd6, 12'h008);     // the word the trap drops
        prog_mem[70] = `RV_MRET;
        epc = 64'd20;   // byte address of word 5
        release_after_reset();
        wait_pc(64'd24, 20, "the store reaching execute");
        irq = 1'b1;
        wait_acks(1, 10, "interrupt acknowledge on the store");
        irq = 1'b0;
        check_u64("pc at irq_ack", pc, `RV_TRAP_VEC);
        check_u64("writes before return", 64'(wr_log.size()), 64'd0);
        wait_pc(`RV_TRAP_VEC + 64'd28, 20, "MRET reaching execute");   // pc just past MRET
        next_cycle();
        check_u64("pc after mret", pc, epc);
        wait_writes(1, 20, "the store after return");
        if (wr_log.size() >= 1) begin
            check_wb("store after return", wr_log[0], bus_write(64'h408, 64'h5a5));
        end
        irq = 1'b1;   // MIE is back on so this one is taken
        wait_acks(2, 20, "second interrupt after return");
        irq = 1'b0;
        check_u64("acks in total", 64'(ack_count), 64'd2);
    endtask

    initial begin
        reset = 1'b0;
        irq   = 1'b0;
        reset_and_heartbeat();
        stores_from_arith();
        loads_under_stall();
        irq_entry();
        mret_return();
        $display("mismatches %0d, timeouts %0d", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
